/* verif/pkt_pipe_chk.sv */
`timescale 1ns/1ps

module pkt_pipe_chk (
  input logic clk,
  input logic reset,
  // fifo flags
  input logic full,
  input logic empty,
  input logic nearly_full,
  input logic rd_en,
  // egress framing
  input logic out_first,
  input logic out_last
);

  // ----------------------------------------------------------------------
  // fifo occupancy flags
  // ----------------------------------------------------------------------
  a_full_empty: assert property (@(posedge clk) disable iff (reset) !(full && empty))
    else $error("fifo full and empty both high");

  a_nearly_full: assert property (@(posedge clk) disable iff (reset) !(nearly_full && full))
    else $error("fifo nearly_full high together with full");

  // no pop request on an empty fifo
  a_pop_empty: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
    else $error("rd_en raised while fifo empty");

  // ----------------------------------------------------------------------
  // egress framing, last exactly 3 cycles after first
  // ----------------------------------------------------------------------
  a_frame: assert property (@(posedge clk) disable iff (reset)
    out_first |-> ##1 (!out_last) [*2] ##1 out_last)
    else $error("out_last not 3 cycles after out_first");

endmodule

// fifo side, framing inputs tied low
bind fifo_pkt pkt_pipe_chk fifo_chk_inst (
  .clk         (clk),
  .reset       (reset),
  .full        (full),
  .empty       (empty),
  .nearly_full (nearly_full),
  .rd_en       (rd_en),
  .out_first   (1'b0),
  .out_last    (1'b0)
);

// egress side, flags it cannot see tied low
bind pkt_egress pkt_pipe_chk egress_chk_inst (
  .clk         (clk),
  .reset       (reset),
  .full        (1'b0),
  .empty       (empty),
  .nearly_full (1'b0),
  .rd_en       (rd_en),
  .out_first   (out_first),
  .out_last    (out_last)
);

/* verif/pkt_pipe_tb.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module pkt_pipe_tb
  import pkt_pkg::*;
;

  localparam int STIM_CYCLES     = 400;
  localparam int BURST_LEN       = 40;                     // dense / sparse alternate
  localparam int WATCHDOG_CYCLES = STIM_CYCLES * 5 + 200;
  localparam int ENTRY_W         = 2 + `PKT_DEST_W + 8;    // first, last, dest, byte

  logic                      clk;
  logic                      reset;
  logic                      in_valid;
  logic [`PKT_DEST_W-1:0]    in_dest;
  pkt_op_t                   in_op;
  logic [`PKT_PAYLOAD_W-1:0] in_payload;
  logic                      in_parity;
  logic                      out_valid;
  logic [7:0]                out_byte;
  logic                      out_first;
  logic                      out_last;
  logic [`PKT_DEST_W-1:0]    out_dest;
  logic [`PKT_CNT_W-1:0]     reject_count;
  logic [`PKT_CNT_W-1:0]     drop_count;
  logic                      fifo_nearly_full;
  logic                      fifo_empty;

  // model state
  integer                    seed = 25;
  int                        strobes = 0;     // packets sent
  int                        delivered = 0;   // packets seen leaving
  int                        fifo_occ = 0;    // entries the model expects buffered
  int                        burst;
  int                        cyc;
  logic [`PKT_CNT_W-1:0]     exp_reject = '0;
  logic [`PKT_CNT_W-1:0]     last_drop = '0;
  logic [ENTRY_W-1:0]        exp_q [$];       // expected output bytes in order
  // two-deep tracker, decision shows on counters 2 edges after the drive
  logic                      pipe_valid [2];
  logic                      pipe_reject [2];
  logic [`PKT_DEST_W-1:0]    pipe_dest [2];
  logic [`PKT_PAYLOAD_W-1:0] pipe_word [2];

  tb_clkgen #(.PERIOD(4.0)) tb_clkgen_inst (.clk(clk));

  pkt_pipe_top pkt_pipe_top_inst (
    .clk              (clk),
    .reset            (reset),
    .in_valid         (in_valid),
    .in_dest          (in_dest),
    .in_op            (in_op),
    .in_payload       (in_payload),
    .in_parity        (in_parity),
    .out_valid        (out_valid),
    .out_byte         (out_byte),
    .out_first        (out_first),
    .out_last         (out_last),
    .out_dest         (out_dest),
    .reject_count     (reject_count),
    .drop_count       (drop_count),
    .fifo_nearly_full (fifo_nearly_full),
    .fifo_empty       (fifo_empty)
  );

  // ----------------------------------------------------------------------
  // failure reporting and compare
  // ----------------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERR t=%0t %s expected=0x%0h actual=0x%0h",
                          $time, name, expected, actual));
    end
  endtask

  // expected payload after the opcode
  function automatic logic [`PKT_PAYLOAD_W-1:0] model_payload(
    input pkt_op_t                   op,
    input logic [`PKT_PAYLOAD_W-1:0] data
  );
    logic [`PKT_PAYLOAD_W-1:0] res;
    int                        b;
    res = data;
    if (op == OP_INVERT) begin
      res = data ^ {`PKT_PAYLOAD_W{1'b1}};
    end else if (op == OP_BSWAP) begin
      for (b = 0; b < 4; b++) begin
        res[8*b +: 8] = data[8*(3-b) +: 8];   // byte b takes byte 3-b
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // per-cycle model
  // ----------------------------------------------------------------------
  // packet driven two edges ago has now been screened and written or dropped
  task automatic check_decision();
    logic [`PKT_CNT_W-1:0] delta;
    int                    i;
    delta = drop_count - last_drop;
    last_drop = drop_count;
    if (pipe_valid[1] && pipe_reject[1]) begin
      exp_reject++;
      check_value("drop_count step", 0, delta);
    end else if (pipe_valid[1]) begin
      // screened while the fifo held DEPTH entries -> overflow drop
      check_value("drop_count step", (fifo_occ == `PKT_FIFO_DEPTH), delta);
      if (delta == 0) begin
        for (i = 3; i >= 0; i--) begin     // msb byte first
          exp_q.push_back({(i == 3), (i == 0), pipe_dest[1], pipe_word[1][8*i +: 8]});
        end
        fifo_occ++;                        // written on the last edge
      end
    end else begin
      check_value("drop_count step", 0, delta);   // nothing in flight
    end
    check_value("reject_count", exp_reject, reject_count);
  endtask

  task automatic check_output();
    logic [ENTRY_W-1:0] entry;
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("output byte appeared while no packet was expected");
      end else begin
        entry = exp_q.pop_front();
        check_value("out_byte", entry[7:0], out_byte);
        check_value("out_dest", entry[8 +: `PKT_DEST_W], out_dest);
        check_value("out_last", entry[ENTRY_W-2], out_last);
        check_value("out_first", entry[ENTRY_W-1], out_first);
        if (out_first) begin
          fifo_occ--;   // head popped on the edge that started this packet
        end
        if (out_last) begin
          delivered++;
        end
      end
    end
  endtask

  // falling edge: check, then drive the next input
  task automatic run_cycle(input logic strobe);
    integer                    rnd;
    logic [`PKT_DEST_W-1:0]    dest;
    pkt_op_t                   op;
    logic [`PKT_PAYLOAD_W-1:0] payload;
    logic                      bad_parity;
    @(negedge clk);
    check_decision();
    check_output();
    check_value("fifo_nearly_full", (fifo_occ == (`PKT_FIFO_DEPTH - 1)), fifo_nearly_full);
    check_value("fifo_empty", (fifo_occ == 0), fifo_empty);
    pipe_valid[1]  = pipe_valid[0];
    pipe_reject[1] = pipe_reject[0];
    pipe_dest[1]   = pipe_dest[0];
    pipe_word[1]   = pipe_word[0];
    pipe_valid[0]  = 1'b0;
    in_valid       = 1'b0;
    if (strobe) begin
      dest       = $random(seed);
      rnd        = $random(seed);
      op         = pkt_op_t'(rnd[1:0]);
      payload    = $random(seed);
      rnd        = $random(seed);
      bad_parity = (rnd[2:0] == 3'd0);   // about 1 in 8
      in_valid   = 1'b1;
      in_dest    = dest;
      in_op      = op;
      in_payload = payload;
      in_parity  = (^{dest, op, payload}) ^ bad_parity;   // even unless injected
      pipe_valid[0]  = 1'b1;
      pipe_reject[0] = bad_parity || (op == OP_DISCARD);
      pipe_dest[0]   = dest;
      pipe_word[0]   = model_payload(op, payload);
      strobes++;
    end
  endtask

  // ----------------------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------------------
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("watchdog expired before the pipeline drained");
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    reset      = 1'b1;
    in_valid   = 1'b0;
    in_dest    = '0;
    in_op      = OP_PASS;
    in_payload = '0;
    in_parity  = 1'b0;
    pipe_valid[0] = 1'b0;
    pipe_valid[1] = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle state out of reset
    check_value("out_valid", 0, out_valid);
    check_value("reject_count", 0, reject_count);
    check_value("drop_count", 0, drop_count);
    check_value("fifo_empty", 1, fifo_empty);

    for (burst = 0; burst < STIM_CYCLES / BURST_LEN; burst++) begin
      for (cyc = 0; cyc < BURST_LEN; cyc++) begin
        if (burst % 2 == 0) begin
          run_cycle(1'b1);                              // dense, fills the fifo
        end else begin
          run_cycle(({$random(seed)} % 6) == 0);       // sparse
        end
      end
    end

    // drain, bounded by the watchdog
    while (pipe_valid[0] || pipe_valid[1] || (exp_q.size() != 0)) begin
      run_cycle(1'b0);
    end
    repeat (12) run_cycle(1'b0);   // any stray byte fails here

    check_value("expected queue size", 0, exp_q.size());
    check_value("fifo_empty", 1, fifo_empty);
    check_value("packet total", strobes, delivered + drop_count + reject_count);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter realtime PERIOD = 4.0   // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;   // known level at time 0
  end

  always #(PERIOD / 2.0) clk = ~clk;   // 50% duty

endmodule

/* verilog/fifo_pkt.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module fifo_pkt
  import pkt_pkg::*;
#(
  parameter int DEPTH = `PKT_FIFO_DEPTH   // power of two
) (
  input  logic    clk,
  input  logic    reset,
  // write side
  input  packet_t din,
  input  logic    wr_en,
  // read side, fall-through
  input  logic    rd_en,
  output packet_t dout,
  // occupancy flags, combinational from pointers
  output logic    full,
  output logic    empty,
  output logic    nearly_full,
  output logic    nearly_empty
);

  localparam int AW = $clog2(DEPTH);   // address bits

  // ----------------------------------------------------------------------
  // storage and pointers
  // ----------------------------------------------------------------------
  packet_t       mem [DEPTH];
  logic [AW:0]   wr_ptr;     // extra msb tracks wrap
  logic [AW:0]   rd_ptr;
  logic [AW-1:0] wr_loc;
  logic [AW-1:0] rd_loc;
  logic [AW:0]   occupancy;  // entries held, 0..DEPTH
  logic          do_write;
  logic          do_read;

  assign wr_loc = wr_ptr[AW-1:0];
  assign rd_loc = rd_ptr[AW-1:0];

  // writes into a full fifo are ignored, same for reads when empty
  assign do_write = wr_en && !full;
  assign do_read  = rd_en && !empty;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;  // both may move in one cycle
      end
    end
  end

  // memory array, no reset
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_loc] <= din;
    end
  end

  // head entry always visible
  assign dout = mem[rd_loc];

  // ----------------------------------------------------------------------
  // flags
  // ----------------------------------------------------------------------
  assign occupancy = wr_ptr - rd_ptr;   // modulo 2*DEPTH, fits in AW+1 bits

  // equal pointers -> empty, msb-only difference -> full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_loc == rd_loc) && (wr_ptr[AW] != rd_ptr[AW]);

  // one slot left / one entry left
  assign nearly_full  = (occupancy == (AW + 1)'(DEPTH - 1));
  assign nearly_empty = (occupancy == (AW + 1)'(1));

endmodule

/* verilog/pkt_egress.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module pkt_egress
  import pkt_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  // fifo head
  input  packet_t                dout,
  input  logic                   empty,
  output logic                   rd_en,
  // byte stream out
  output logic                   out_valid,
  output logic [7:0]             out_byte,
  output logic                   out_first,
  output logic                   out_last,
  output logic [`PKT_DEST_W-1:0] out_dest
);

  eg_state_t                 state;
  logic [`PKT_PAYLOAD_W-1:0] shreg;     // transformed payload, msb byte out
  logic [`PKT_DEST_W-1:0]    dest_q;    // tag held for the whole packet
  logic [1:0]                byte_cnt;  // 3 down to 0
  logic                      take;      // pop head this cycle

  // ----------------------------------------------------------------------
  // opcode transform
  // ----------------------------------------------------------------------
  function automatic logic [`PKT_PAYLOAD_W-1:0] apply_op(
    input pkt_op_t                   op,
    input logic [`PKT_PAYLOAD_W-1:0] data
  );
    logic [`PKT_PAYLOAD_W-1:0] res;
    case (op)
      OP_INVERT: res = ~data;
      OP_BSWAP:  res = {data[7:0], data[15:8], data[23:16], data[31:24]};
      default:   res = data;   // pass; discard never reaches egress
    endcase
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // pop control
  // ----------------------------------------------------------------------
  assign take  = (state == EG_IDLE) && !empty;
  assign rd_en = take;   // single cycle, idle state lasts one cycle per pop

  // ----------------------------------------------------------------------
  // state machine and serializer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= EG_IDLE;
      byte_cnt <= 2'd0;
    end else begin
      case (state)
        EG_IDLE: begin
          if (take) begin
            state    <= EG_SEND;
            byte_cnt <= 2'd3;          // first byte out next cycle
          end
        end
        EG_SEND: begin
          byte_cnt <= byte_cnt - 2'd1;
          if (byte_cnt == 2'd0) begin
            state <= EG_IDLE;          // last byte leaving now
          end
        end
        default: state <= EG_IDLE;
      endcase
    end
  end

  // payload path, loaded on pop and shifted per byte
  always_ff @(posedge clk) begin
    if (take) begin
      shreg  <= apply_op(dout.op, dout.payload);
      dest_q <= dout.dest;
    end else if (state == EG_SEND) begin
      shreg <= {shreg[`PKT_PAYLOAD_W-9:0], 8'h00};   // next byte to top
    end
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------
  assign out_valid = (state == EG_SEND);
  assign out_byte  = shreg[`PKT_PAYLOAD_W-1 -: 8];
  assign out_first = out_valid && (byte_cnt == 2'd3);   // byte 3
  assign out_last  = out_valid && (byte_cnt == 2'd0);   // byte 0
  assign out_dest  = dest_q;

endmodule

/* verilog/pkt_ingress.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module pkt_ingress
  import pkt_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  // source side, one strobe per packet
  input  logic                      in_valid,
  input  logic [`PKT_DEST_W-1:0]    in_dest,
  input  pkt_op_t                   in_op,
  input  logic [`PKT_PAYLOAD_W-1:0] in_payload,
  input  logic                      in_parity,
  // fifo side
  input  logic                      full,
  output logic                      wr_en,
  output packet_t                   din,
  // status
  output logic [`PKT_CNT_W-1:0]     reject_count,
  output logic [`PKT_CNT_W-1:0]     drop_count
);

  logic    valid_q;    // registered strobe
  packet_t pkt_q;      // registered fields
  logic    parity_q;   // registered parity bit
  logic    parity_ok;  // even parity over fields + parity bit
  logic    screen_ok;  // passes parity and opcode screen
  logic    reject;
  logic    drop;

  // ----------------------------------------------------------------------
  // input register stage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  // fields only load on a strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      pkt_q.dest    <= in_dest;
      pkt_q.op      <= in_op;
      pkt_q.payload <= in_payload;
      parity_q      <= in_parity;
    end
  end

  // ----------------------------------------------------------------------
  // screening, on the registered copy
  // ----------------------------------------------------------------------
  assign parity_ok = ~(^{pkt_q, parity_q});         // xor of all bits must be 0
  assign screen_ok = parity_ok && (pkt_q.op != OP_DISCARD);

  assign reject = valid_q && !screen_ok;
  assign drop   = valid_q && screen_ok && full;     // overflow, no room

  // write strobe only for accepted packets with space
  assign wr_en = valid_q && screen_ok && !full;
  assign din   = pkt_q;

  // ----------------------------------------------------------------------
  // saturating counters
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reject_count <= '0;
    end else if (reject && (reject_count != '1)) begin
      reject_count <= reject_count + 1'b1;  // stick at max
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      drop_count <= '0;
    end else if (drop && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

/* verilog/pkt_macros.svh */
`ifndef PKT_MACROS_SVH
`define PKT_MACROS_SVH

// ----------------------------------------------------------------------
// packet field widths
// ----------------------------------------------------------------------
`define PKT_PAYLOAD_W  32   // payload bits, serialized as 4 bytes
`define PKT_DEST_W     4    // destination tag

// ----------------------------------------------------------------------
// buffer and status sizing
// ----------------------------------------------------------------------
`define PKT_FIFO_DEPTH 8    // entries, power of two
`define PKT_CNT_W      16   // reject / drop counters, saturating

`endif

/* verilog/pkt_pipe_top.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module pkt_pipe_top
  import pkt_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  // packet input
  input  logic                      in_valid,
  input  logic [`PKT_DEST_W-1:0]    in_dest,
  input  pkt_op_t                   in_op,
  input  logic [`PKT_PAYLOAD_W-1:0] in_payload,
  input  logic                      in_parity,
  // byte output
  output logic                      out_valid,
  output logic [7:0]                out_byte,
  output logic                      out_first,
  output logic                      out_last,
  output logic [`PKT_DEST_W-1:0]    out_dest,
  // status
  output logic [`PKT_CNT_W-1:0]     reject_count,
  output logic [`PKT_CNT_W-1:0]     drop_count,
  output logic                      fifo_nearly_full,
  output logic                      fifo_empty
);

  // ----------------------------------------------------------------------
  // inter-stage wires
  // ----------------------------------------------------------------------
  packet_t din;    // ingress -> fifo
  packet_t dout;   // fifo head -> egress
  logic    wr_en;
  logic    rd_en;
  logic    full;

  pkt_ingress pkt_ingress_inst (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_dest      (in_dest),
    .in_op        (in_op),
    .in_payload   (in_payload),
    .in_parity    (in_parity),
    .full         (full),
    .wr_en        (wr_en),
    .din          (din),
    .reject_count (reject_count),
    .drop_count   (drop_count)
  );

  fifo_pkt #(
    .DEPTH (`PKT_FIFO_DEPTH)
  ) fifo_pkt_inst (
    .clk          (clk),
    .reset        (reset),
    .din          (din),
    .wr_en        (wr_en),
    .rd_en        (rd_en),
    .dout         (dout),
    .full         (full),
    .empty        (fifo_empty),
    .nearly_full  (fifo_nearly_full),
    .nearly_empty ()              // not brought out
  );

  pkt_egress pkt_egress_inst (
    .clk       (clk),
    .reset     (reset),
    .dout      (dout),
    .empty     (fifo_empty),
    .rd_en     (rd_en),
    .out_valid (out_valid),
    .out_byte  (out_byte),
    .out_first (out_first),
    .out_last  (out_last),
    .out_dest  (out_dest)
  );

endmodule

/* verilog/pkt_pkg.sv */
`include "pkt_macros.svh"

package pkt_pkg;

  // ----------------------------------------------------------------------
  // opcodes carried with each packet
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    OP_PASS    = 2'd0,  // payload unchanged
    OP_INVERT  = 2'd1,  // all payload bits flipped
    OP_BSWAP   = 2'd2,  // byte order reversed
    OP_DISCARD = 2'd3   // dropped by ingress screening
  } pkt_op_t;

  // ----------------------------------------------------------------------
  // egress serializer states
  // ----------------------------------------------------------------------
  typedef enum logic {
    EG_IDLE = 1'b0,     // waiting for a head entry
    EG_SEND = 1'b1      // shifting out 4 bytes
  } eg_state_t;

  // ----------------------------------------------------------------------
  // buffered packet, 38 bits
  // parity is checked at ingress and not stored
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`PKT_DEST_W-1:0]    dest;     // msbs
    pkt_op_t                   op;
    logic [`PKT_PAYLOAD_W-1:0] payload;  // lsbs
  } packet_t;

endpackage

/* vlog.f */
+incdir+verilog
verilog/pkt_pkg.sv
verilog/pkt_ingress.sv
verilog/fifo_pkt.sv
verilog/pkt_egress.sv
verilog/pkt_pipe_top.sv
verif/tb_clkgen.sv
verif/pkt_pipe_chk.sv
verif/pkt_pipe_tb.sv
